/* compile.f */
hw/cache_pkg.sv
hw/cache_ifs.sv
hw/access_sequencer.sv
hw/tag_directory.sv
hw/plru_victim.sv
hw/data_array.sv
hw/read_select.sv
hw/cache_ctrl_top.sv
tests/cache_checker.sv
tests/tb_cache_ctrl.sv

/* hw/access_sequencer.sv */
`timescale 1ns/1ps

module access_sequencer import cache_pkg::*; #(
    parameter int SETS = 16
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  op_e                      req_op_i,
    input  logic [$clog2(SETS)-1:0]  req_set_i,
    input  tag_t                     req_tag_i,
    input  word_idx_t                req_word_i,
    input  word_t                    req_wdata_i,
    input  be_t                      req_be_i,
    input  line_t                    req_line_i,
    output logic                     ready_o,
    output op_e                      s1_op_o,
    dir_if.seq                       dir,
    data_if.seq                      data
);
    localparam int SET_W = $clog2(SETS);

    typedef enum logic {
        INIT,
        RUN
    } state_e;

    state_e           state_q;
    logic [SET_W-1:0] sweep_set_q;
    op_e              op;

    op_e              s1_op_q;
    logic [SET_W-1:0] s1_set_q;
    word_idx_t        s1_word_q;
    word_t            s1_wdata_q;
    be_t              s1_be_q;

    // One set cleared per cycle, then switch to normal operation
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= INIT;
            sweep_set_q <= '0;
        end else if (state_q == INIT) begin
            sweep_set_q <= sweep_set_q + 1'b1;
            if (sweep_set_q == SET_W'(SETS - 1)) begin
                state_q <= RUN;
            end
        end
    end

    assign ready_o = (state_q == RUN);

    // Requests are dropped during the sweep
    assign op = ready_o ? req_op_i : OP_NONE;

    assign dir.clear  = !ready_o;
    assign dir.set    = ready_o ? req_set_i : sweep_set_q;
    assign dir.lookup = (op == OP_LOAD) || (op == OP_STORE);
    assign dir.refill = (op == OP_REFILL);
    assign dir.tag    = req_tag_i;

    assign data.read   = (op == OP_LOAD);
    assign data.refill = (op == OP_REFILL);
    assign data.set    = req_set_i;
    assign data.word   = req_word_i;
    assign data.line   = req_line_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            s1_op_q <= OP_NONE;
        end else begin
            s1_op_q <= op;
        end
    end

    // Stage-1 payload, only meaningful alongside s1_op_q
    always_ff @(posedge clk_i) begin
        if (op != OP_NONE) begin
            s1_set_q   <= req_set_i;
            s1_word_q  <= req_word_i;
            s1_wdata_q <= req_wdata_i;
            s1_be_q    <= req_be_i;
        end
    end

    assign s1_op_o       = s1_op_q;
    assign data.s1_store = (s1_op_q == OP_STORE);
    assign data.s1_set   = s1_set_q;
    assign data.s1_word  = s1_word_q;
    assign data.s1_wdata = s1_wdata_q;
    assign data.s1_be    = s1_be_q;

    // Requester must wait for the end of the sweep
    no_req_before_ready_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !ready_o |-> req_op_i == OP_NONE)
        else $error("access_sequencer: request while ready_o is low");

endmodule

/* hw/cache_ctrl_top.sv */
`timescale 1ns/1ps

module cache_ctrl_top import cache_pkg::*; #(
    parameter int SETS = 16
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  op_e                      req_op_i,
    input  logic [$clog2(SETS)-1:0]  req_set_i,
    input  tag_t                     req_tag_i,
    input  word_idx_t                req_word_i,
    input  word_t                    req_wdata_i,
    input  be_t                      req_be_i,
    input  line_t                    req_line_i,
    output logic                     ready_o,
    output logic                     resp_valid_o,
    output op_e                      resp_op_o,
    output logic                     resp_hit_o,
    output way_vec_t                 resp_way_o,
    output word_t                    resp_rdata_o
);
    op_e      s1_op;
    way_vec_t victim_way_q;

    dir_if  #(.SETS(SETS)) dir_bus  ();
    data_if #(.SETS(SETS)) data_bus ();

    access_sequencer #(.SETS(SETS)) u_seq (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .req_op_i    (req_op_i),
        .req_set_i   (req_set_i),
        .req_tag_i   (req_tag_i),
        .req_word_i  (req_word_i),
        .req_wdata_i (req_wdata_i),
        .req_be_i    (req_be_i),
        .req_line_i  (req_line_i),
        .ready_o     (ready_o),
        .s1_op_o     (s1_op),
        .dir         (dir_bus.seq),
        .data        (data_bus.seq)
    );

    tag_directory #(.SETS(SETS)) u_dir (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .dir    (dir_bus.dir)
    );

    // Stage-1 set doubles as the PLRU hit set
    plru_victim #(.SETS(SETS)) u_plru (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .dir            (dir_bus.repl),
        .hit_way_i      (dir_bus.hit_way),
        .hit_set_i      (data_bus.s1_set),
        .victim_way_q_o (victim_way_q)
    );

    data_array #(.SETS(SETS)) u_data (
        .clk_i        (clk_i),
        .data         (data_bus.mem),
        .hit_way_i    (dir_bus.hit_way),
        .victim_way_i (dir_bus.victim_way)
    );

    read_select u_rsel (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .s1_op_i        (s1_op),
        .hit_way_i      (dir_bus.hit_way),
        .victim_way_q_i (victim_way_q),
        .rdata_ways_i   (data_bus.rdata_ways),
        .resp_valid_o   (resp_valid_o),
        .resp_op_o      (resp_op_o),
        .resp_hit_o     (resp_hit_o),
        .resp_way_o     (resp_way_o),
        .resp_rdata_o   (resp_rdata_o)
    );

endmodule

/* hw/cache_ifs.sv */
`timescale 1ns/1ps

// Directory access: sequencer, tag directory and replacement logic
interface dir_if import cache_pkg::*; #(
    parameter int SETS = 16
) ();
    localparam int SET_W = $clog2(SETS);

    logic             lookup;
    logic             refill;
    logic             clear;
    logic [SET_W-1:0] set;
    tag_t             tag;

    // Hit mask of the set looked up one cycle earlier
    way_vec_t         hit_way;
    // Valid mask of the set addressed now
    way_vec_t         set_valid;
    way_vec_t         victim_way;

    modport seq (
        output lookup, refill, clear, set, tag
    );

    modport dir (
        input  lookup, refill, clear, set, tag, victim_way,
        output hit_way, set_valid
    );

    modport repl (
        input  refill, clear, set, set_valid,
        output victim_way
    );
endinterface

// Data access: cycle-N read and refill, stage-1 store
interface data_if import cache_pkg::*; #(
    parameter int SETS = 16
) ();
    localparam int SET_W = $clog2(SETS);

    logic              read;
    logic              refill;
    logic [SET_W-1:0]  set;
    word_idx_t         word;
    line_t             line;

    logic              s1_store;
    logic [SET_W-1:0]  s1_set;
    word_idx_t         s1_word;
    word_t             s1_wdata;
    be_t               s1_be;

    word_t [WAYS-1:0]  rdata_ways;

    modport seq (
        output read, refill, set, word, line,
        output s1_store, s1_set, s1_word, s1_wdata, s1_be
    );

    modport mem (
        input  read, refill, set, word, line,
        input  s1_store, s1_set, s1_word, s1_wdata, s1_be,
        output rdata_ways
    );
endinterface

/* hw/cache_pkg.sv */
package cache_pkg;

    // Geometry, way count is tied to the 4-way PLRU tree
    localparam int WAYS       = 4;
    localparam int TAG_W      = 10;
    localparam int WORD_W     = 32;
    localparam int LINE_WORDS = 4;
    localparam int WORD_IDX_W = 2;

    typedef logic [TAG_W-1:0]             tag_t;
    typedef logic [WORD_W-1:0]            word_t;
    typedef logic [WORD_W/8-1:0]          be_t;
    typedef logic [WORD_IDX_W-1:0]        word_idx_t;

    // Word 0 sits in the lowest bits
    typedef logic [LINE_WORDS*WORD_W-1:0] line_t;

    typedef logic [WAYS-1:0]              way_vec_t;

    typedef enum logic [1:0] {
        OP_NONE   = 2'd0,
        OP_LOAD   = 2'd1,
        OP_STORE  = 2'd2,
        OP_REFILL = 2'd3
    } op_e;

endpackage

/* hw/data_array.sv */
`timescale 1ns/1ps

module data_array import cache_pkg::*; #(
    parameter int SETS = 16
) (
    input  logic     clk_i,
    data_if.mem      data,
    input  way_vec_t hit_way_i,
    input  way_vec_t victim_way_i
);
    localparam int BYTES = WORD_W / 8;

    // One line per set and way, kept as separate words
    word_t            mem_q [SETS][WAYS][LINE_WORDS];
    word_t [WAYS-1:0] rdata_q;

    always_ff @(posedge clk_i) begin
        for (int w = 0; w < WAYS; w++) begin
            // Stage-1 store, only into the way that hit
            if (data.s1_store && hit_way_i[w]) begin
                for (int b = 0; b < BYTES; b++) begin
                    if (data.s1_be[b]) begin
                        mem_q[data.s1_set][w][data.s1_word][8*b +: 8] <=
                            data.s1_wdata[8*b +: 8];
                    end
                end
            end
            // Whole line into the victim
            if (data.refill && victim_way_i[w]) begin
                for (int i = 0; i < LINE_WORDS; i++) begin
                    mem_q[data.set][w][i] <= data.line[i*WORD_W +: WORD_W];
                end
            end
        end
    end

    // Same word of every way, the hit way is picked one stage later
    always_ff @(posedge clk_i) begin
        if (data.read) begin
            for (int w = 0; w < WAYS; w++) begin
                rdata_q[w] <= mem_q[data.set][w][data.word];
            end
        end
    end

    assign data.rdata_ways = rdata_q;

    // A refill covers the whole line, so overlap is only a matter of set and way
    no_write_overlap_a: assert property (@(posedge clk_i)
        (data.refill && data.s1_store && |(hit_way_i & victim_way_i))
            |-> data.set != data.s1_set)
        else $error("data_array: refill and store hit the same line");

endmodule

/* hw/plru_victim.sv */
`timescale 1ns/1ps

module plru_victim import cache_pkg::*; #(
    parameter int SETS = 16
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    dir_if.repl                      dir,
    input  way_vec_t                 hit_way_i,
    input  logic [$clog2(SETS)-1:0]  hit_set_i,
    output way_vec_t                 victim_way_q_o
);
    // Bit 0 is the root, bit 1 the leaf of ways 0-1, bit 2 the leaf of ways 2-3
    logic [2:0] tree_q [SETS];
    logic [2:0] cur_tree;
    logic [2:0] hit_tree;
    logic [2:0] refill_base;
    logic [2:0] refill_tree;
    way_vec_t   tree_way;
    way_vec_t   victim;
    way_vec_t   victim_q;
    logic       hit_upd;

    // Point root and leaf away from the accessed way
    function automatic logic [2:0] touch(input logic [2:0] tree, input way_vec_t way);
        logic       upper;
        logic       odd;
        logic [2:0] next;
        upper   = way[2] | way[3];
        odd     = way[1] | way[3];
        next    = tree;
        next[0] = ~upper;
        if (upper) begin
            next[2] = ~odd;
        end else begin
            next[1] = ~odd;
        end
        return next;
    endfunction

    assign hit_upd  = |hit_way_i;
    assign cur_tree = tree_q[dir.set];
    assign hit_tree = touch(tree_q[hit_set_i], hit_way_i);

    // Hit update goes first when both touch the same set
    assign refill_base = (hit_upd && hit_set_i == dir.set) ? hit_tree : cur_tree;
    assign refill_tree = touch(refill_base, victim);

    always_comb begin
        tree_way = '0;
        if (!cur_tree[0]) begin
            tree_way[cur_tree[1] ? 1 : 0] = 1'b1;
        end else begin
            tree_way[cur_tree[2] ? 3 : 2] = 1'b1;
        end
    end

    // Lowest invalid way wins over the tree
    always_comb begin
        victim = tree_way;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!dir.set_valid[w]) begin
                victim = way_vec_t'(1 << w);
            end
        end
    end

    assign dir.victim_way = victim;

    always_ff @(posedge clk_i) begin
        if (dir.clear) begin
            tree_q[dir.set] <= '0;
        end else begin
            if (hit_upd) begin
                tree_q[hit_set_i] <= hit_tree;
            end
            if (dir.refill) begin
                tree_q[dir.set] <= refill_tree;
            end
        end
    end

    // Victim carried along with the refill into stage 1
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            victim_q <= '0;
        end else if (dir.refill) begin
            victim_q <= victim;
        end
    end

    assign victim_way_q_o = victim_q;

    // The way hit in the previous cycle is never the next victim of that set
    victim_not_mru_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ($past(hit_upd) && dir.set == $past(hit_set_i))
            |-> (dir.victim_way & $past(hit_way_i)) == '0)
        else $error("plru_victim: victim is the way hit one cycle earlier");

endmodule

/* hw/read_select.sv */
`timescale 1ns/1ps

module read_select import cache_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  op_e              s1_op_i,
    input  way_vec_t         hit_way_i,
    input  way_vec_t         victim_way_q_i,
    input  word_t [WAYS-1:0] rdata_ways_i,
    output logic             resp_valid_o,
    output op_e              resp_op_o,
    output logic             resp_hit_o,
    output way_vec_t         resp_way_o,
    output word_t            resp_rdata_o
);
    word_t    sel_word;
    logic     s1_hit;
    logic     valid_q;
    op_e      op_q;
    logic     hit_q;
    way_vec_t way_q;
    word_t    rdata_q;

    // One-hot AND-OR mux on the hit mask
    always_comb begin
        sel_word = '0;
        for (int w = 0; w < WAYS; w++) begin
            sel_word = sel_word | (rdata_ways_i[w] & {WORD_W{hit_way_i[w]}});
        end
    end

    assign s1_hit = |hit_way_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
            op_q    <= OP_NONE;
        end else begin
            valid_q <= (s1_op_i != OP_NONE);
            op_q    <= s1_op_i;
        end
    end

    always_ff @(posedge clk_i) begin
        hit_q   <= (s1_op_i == OP_REFILL) || s1_hit;
        way_q   <= (s1_op_i == OP_REFILL) ? victim_way_q_i : hit_way_i;
        rdata_q <= (s1_op_i == OP_LOAD && s1_hit) ? sel_word : '0;
    end

    assign resp_valid_o = valid_q;
    assign resp_op_o    = op_q;
    assign resp_hit_o   = hit_q;
    assign resp_way_o   = way_q;
    assign resp_rdata_o = rdata_q;

endmodule

/* hw/tag_directory.sv */
`timescale 1ns/1ps

module tag_directory import cache_pkg::*; #(
    parameter int SETS = 16
) (
    input  logic clk_i,
    input  logic rst_ni,
    dir_if.dir   dir
);
    localparam int SET_W = $clog2(SETS);

    tag_t                  tags_q [SETS][WAYS];
    way_vec_t [SETS-1:0]   valid_q;

    logic                  lookup_q;
    logic [SET_W-1:0]      lk_set_q;
    tag_t                  lk_tag_q;
    way_vec_t              match;

    // Tags are zeroed by the sweep, refill writes the victim way only
    always_ff @(posedge clk_i) begin
        if (dir.clear) begin
            for (int w = 0; w < WAYS; w++) begin
                tags_q[dir.set][w] <= '0;
            end
        end else if (dir.refill) begin
            for (int w = 0; w < WAYS; w++) begin
                if (dir.victim_way[w]) begin
                    tags_q[dir.set][w] <= dir.tag;
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (dir.refill) begin
            valid_q[dir.set] <= valid_q[dir.set] | dir.victim_way;
        end
    end

    assign dir.set_valid = valid_q[dir.set];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lookup_q <= 1'b0;
        end else begin
            lookup_q <= dir.lookup;
        end
    end

    always_ff @(posedge clk_i) begin
        if (dir.lookup) begin
            lk_set_q <= dir.set;
            lk_tag_q <= dir.tag;
        end
    end

    // Compare in the cycle after the lookup. No directory write can land
    // in between, since the lookup itself owns cycle N
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            match[w] = valid_q[lk_set_q][w] && (tags_q[lk_set_q][w] == lk_tag_q);
        end
    end

    assign dir.hit_way = lookup_q ? match : '0;

    // Refills never leave two valid copies of one tag in a set
    hit_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(dir.hit_way))
        else $error("tag_directory: multiple ways hit");

endmodule

/* run.sh */
#!/bin/sh
# Build and run the cache controller testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_cache_ctrl -o sim_cache || exit 1
./obj_dir/sim_cache > sim.log 2>&1
cat sim.log
grep -qx "Result: PASSED" sim.log && exit 0 || exit 1

/* tests/cache_checker.sv */
`timescale 1ns/1ps

module cache_checker import cache_pkg::*; (
    input  logic     clk_i,
    input  int       cycle_i,
    input  logic     resp_valid_o,
    input  op_e      resp_op_o,
    input  logic     resp_hit_o,
    input  way_vec_t resp_way_o,
    input  word_t    resp_rdata_o,
    output int       errors_o
);
    typedef struct {
        int       due;
        op_e      op;
        logic     hit;
        way_vec_t way;
        word_t    rdata;
    } exp_t;

    exp_t exp_q[$];
    int   errors = 0;

    assign errors_o = errors;

    // Called by the testbench once per issued request
    function void push_expected(input int due, input op_e op, input logic hit,
                                input way_vec_t way, input word_t rdata);
        exp_t e;
        e.due   = due;
        e.op    = op;
        e.hit   = hit;
        e.way   = way;
        e.rdata = rdata;
        exp_q.push_back(e);
    endfunction

    function int pending_count();
        return exp_q.size();
    endfunction

    function void compare_field(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h (cycle %0d)",
                     name, got, exp, cycle_i);
            errors++;
        end
    endfunction

    // Outputs are registered on the rising edge, so the falling edge sees them settled
    always @(negedge clk_i) begin
        exp_t e;
        if (exp_q.size() > 0 && exp_q[0].due < cycle_i) begin
            $display("Response due in cycle %0d never arrived", exp_q[0].due);
            errors++;
            void'(exp_q.pop_front());
        end
        if (resp_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected response in cycle %0d with nothing outstanding",
                         cycle_i);
                errors++;
            end else begin
                e = exp_q.pop_front();
                if (e.due != cycle_i) begin
                    $display("Response in cycle %0d, but it was due in cycle %0d",
                             cycle_i, e.due);
                    errors++;
                end
                compare_field("resp_op_o", 32'(resp_op_o), 32'(e.op));
                compare_field("resp_hit_o", 32'(resp_hit_o), 32'(e.hit));
                compare_field("resp_way_o", 32'(resp_way_o), 32'(e.way));
                compare_field("resp_rdata_o", resp_rdata_o, e.rdata);
            end
        end
    end

endmodule

/* tests/tb_cache_ctrl.sv */
`timescale 1ns/1ps

module tb_cache_ctrl import cache_pkg::*; ();
    localparam int SETS     = 16;
    localparam int SET_W    = $clog2(SETS);
    localparam int N_RANDOM = 300;
    // Directed phases plus random mix and drain
    localparam int STIM_CYCLES = SETS + 8 + 5 * LINE_WORDS + 8 + N_RANDOM + 4;
    localparam int LIMIT       = 2 * STIM_CYCLES + SETS + 20;

    typedef struct packed {
        logic     hit;
        way_vec_t way;
        word_t    rdata;
    } resp_t;

    logic             clk = 1'b0;
    logic             rst_ni;
    op_e              req_op_i;
    logic [SET_W-1:0] req_set_i;
    tag_t             req_tag_i;
    word_idx_t        req_word_i;
    word_t            req_wdata_i;
    be_t              req_be_i;
    line_t            req_line_i;
    logic             ready_o;
    logic             resp_valid_o;
    op_e              resp_op_o;
    logic             resp_hit_o;
    way_vec_t         resp_way_o;
    word_t            resp_rdata_o;

    integer seed   = 95;
    int     cycle  = 0;
    int     errors = 0;
    int     chk_errors;

    // Reference state
    tag_t       m_tags [SETS][WAYS];
    way_vec_t   m_valid [SETS];
    logic [2:0] m_tree [SETS];
    word_t      m_mem [SETS][WAYS][LINE_WORDS];
    logic             hp_valid;
    logic [SET_W-1:0] hp_set;
    way_vec_t         hp_way;
    logic             st_valid;
    logic [SET_W-1:0] st_set;
    int               st_way;
    word_idx_t        st_word;
    word_t            st_wdata;
    be_t              st_be;

    cache_ctrl_top #(.SETS(SETS)) dut (.*, .clk_i(clk));

    cache_checker chk (
        .clk_i(clk), .cycle_i(cycle), .resp_valid_o(resp_valid_o), .resp_op_o(resp_op_o),
        .resp_hit_o(resp_hit_o), .resp_way_o(resp_way_o), .resp_rdata_o(resp_rdata_o),
        .errors_o(chk_errors)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    always @(negedge clk) begin
        cycle <= cycle + 1;
    end

    always @(negedge clk) begin
        if (cycle >= LIMIT) begin
            $display("Timeout after %0d cycles, the run did not finish", cycle);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic int way_index(input way_vec_t way);
        int idx;
        idx = 0;
        for (int w = 0; w < WAYS; w++) begin
            if (way[w]) begin
                idx = w;
            end
        end
        return idx;
    endfunction

    // Tree bits: [0] root (1 = pair 2-3), [1] leaf of 0-1, [2] leaf of 2-3
    function automatic logic [2:0] touch_tree(input logic [2:0] t, input int w);
        logic [2:0] n;
        n = t;
        n[0] = (w < 2);
        n[(w < 2) ? 1 : 2] = (w % 2 == 0);
        return n;
    endfunction

    function automatic way_vec_t lookup_hit(input logic [SET_W-1:0] set, input tag_t tag);
        way_vec_t h;
        h = '0;
        for (int w = 0; w < WAYS; w++) begin
            h[w] = m_valid[set][w] && (m_tags[set][w] == tag);
        end
        return h;
    endfunction

    function automatic way_vec_t pick_victim(input logic [SET_W-1:0] set);
        logic [2:0] t;
        t = m_tree[set];
        for (int w = 0; w < WAYS; w++) begin
            if (!m_valid[set][w]) begin
                return way_vec_t'(1 << w);
            end
        end
        if (!t[0]) begin
            return t[1] ? 4'b0010 : 4'b0001;
        end
        return t[2] ? 4'b1000 : 4'b0100;
    endfunction

    // One cycle of the reference model; writes from earlier requests land after reads
    function automatic resp_t predict_response(input op_e op, input logic [SET_W-1:0] set,
            input tag_t tag, input word_idx_t word, input word_t wdata, input be_t be,
            input line_t line);
        resp_t    r;
        way_vec_t hit;
        way_vec_t victim;
        int       v;
        r = '0;
        hit = lookup_hit(set, tag);
        victim = pick_victim(set);
        v = way_index(victim);
        if (op == OP_LOAD || op == OP_STORE) begin
            r.hit = |hit;
            r.way = hit;
            if (op == OP_LOAD && |hit) begin
                r.rdata = m_mem[set][way_index(hit)][word];
            end
        end else if (op == OP_REFILL) begin
            r.hit = 1'b1;
            r.way = victim;
        end
        if (st_valid) begin
            for (int b = 0; b < 4; b++) begin
                if (st_be[b]) begin
                    m_mem[st_set][st_way][st_word][8*b +: 8] = st_wdata[8*b +: 8];
                end
            end
        end
        if (hp_valid) begin
            m_tree[hp_set] = touch_tree(m_tree[hp_set], way_index(hp_way));
        end
        if (op == OP_REFILL) begin
            m_tags[set][v] = tag;
            m_valid[set][v] = 1'b1;
            for (int i = 0; i < LINE_WORDS; i++) begin
                m_mem[set][v][i] = line[i*WORD_W +: WORD_W];
            end
            m_tree[set] = touch_tree(m_tree[set], v);
        end
        hp_valid = (op == OP_LOAD || op == OP_STORE) && |hit;
        hp_set   = set;
        hp_way   = hit;
        st_valid = (op == OP_STORE) && |hit;
        st_set   = set;
        st_way   = way_index(hit);
        st_word  = word;
        st_wdata = wdata;
        st_be    = be;
        return r;
    endfunction

    function automatic line_t random_line();
        line_t l;
        for (int i = 0; i < LINE_WORDS; i++) begin
            l[i*WORD_W +: WORD_W] = $random(seed);
        end
        return l;
    endfunction

    task automatic issue(input op_e op, input logic [SET_W-1:0] set, input tag_t tag,
            input word_idx_t word, input word_t wdata, input be_t be, input line_t line);
        resp_t r;
        @(posedge clk);
        req_op_i    <= op;
        req_set_i   <= set;
        req_tag_i   <= tag;
        req_word_i  <= word;
        req_wdata_i <= wdata;
        req_be_i    <= be;
        req_line_i  <= line;
        r = predict_response(op, set, tag, word, wdata, be, line);
        if (op != OP_NONE) begin
            chk.push_expected(cycle + 2, op, r.hit, r.way, r.rdata);
        end
    endtask

    task automatic random_mix();
        op_e              op;
        logic [SET_W-1:0] set;
        tag_t             tag;
        for (int n = 0; n < N_RANDOM; n++) begin
            op  = op_e'(2'($random(seed)));
            set = SET_W'({$random(seed)} % SETS);
            tag = tag_t'(10'h020 + {$random(seed)} % 5);
            // No duplicate tags, and no refill over the line a pending store writes
            if (op == OP_REFILL && (|lookup_hit(set, tag) || (st_valid && st_set == set
                    && way_index(pick_victim(set)) == st_way))) begin
                op = OP_LOAD;
            end
            issue(op, set, tag, word_idx_t'($random(seed)), $random(seed),
                  be_t'($random(seed)), random_line());
        end
    endtask

    initial begin
        int   n;
        tag_t tags [5];
        word_t wd;
        for (int s = 0; s < SETS; s++) begin
            m_valid[s] = '0;
            m_tree[s]  = '0;
            for (int w = 0; w < WAYS; w++) begin
                m_tags[s][w] = '0;
            end
        end
        hp_valid = 1'b0;
        st_valid = 1'b0;
        rst_ni      = 1'b0;
        req_op_i    = OP_NONE;
        req_set_i   = '0;
        req_tag_i   = '0;
        req_word_i  = '0;
        req_wdata_i = '0;
        req_be_i    = '0;
        req_line_i  = '0;
        repeat (5) @(posedge clk);
        rst_ni <= 1'b1;

        // Sweep length
        n = 0;
        do begin
            @(posedge clk);
            n++;
            #1;
        end while (!ready_o && n < 4 * SETS);
        if (n != SETS) begin
            $display("ready_o rose %0d cycles after reset instead of %0d", n, SETS);
            errors++;
        end
        for (int s = 0; s < SETS; s++) begin
            issue(OP_LOAD, SET_W'(s), 10'h011, '0, '0, '0, '0);
        end

        // Fill set 5, touch ways 0 and 2, then replace by PLRU
        for (int i = 0; i < 5; i++) begin
            tags[i] = tag_t'(10'h040 + i);
        end
        for (int i = 0; i < 4; i++) begin
            issue(OP_REFILL, 4'd5, tags[i], '0, '0, '0, random_line());
        end
        issue(OP_LOAD, 4'd5, tags[0], 2'd1, '0, '0, '0);
        issue(OP_LOAD, 4'd5, tags[2], 2'd3, '0, '0, '0);
        issue(OP_REFILL, 4'd5, tags[4], '0, '0, '0, random_line());

        for (int i = 0; i < 5; i++) begin
            for (int k = 0; k < LINE_WORDS; k++) begin
                issue(OP_LOAD, 4'd5, tags[i], word_idx_t'(k), '0, '0, '0);
            end
        end

        // Store merge, hazard load, later load, store miss
        wd = $random(seed);
        issue(OP_STORE, 4'd5, tags[3], 2'd2, wd, be_t'($random(seed)), '0);
        issue(OP_LOAD, 4'd5, tags[3], 2'd2, '0, '0, '0);
        issue(OP_LOAD, 4'd5, tags[3], 2'd2, '0, '0, '0);
        issue(OP_STORE, 4'd5, 10'h3ff, 2'd2, ~wd, 4'hf, '0);
        issue(OP_NONE, '0, '0, '0, '0, '0, '0);
        issue(OP_LOAD, 4'd5, tags[3], 2'd2, '0, '0, '0);
        issue(OP_LOAD, 4'd5, 10'h3ff, 2'd2, '0, '0, '0);

        random_mix();

        repeat (4) begin
            issue(OP_NONE, '0, '0, '0, '0, '0, '0);
        end
        @(negedge clk);
        if (chk.pending_count() != 0) begin
            $display("%0d expected responses never arrived", chk.pending_count());
            errors++;
        end
        #1;
        $display("Errors: %0d", errors + chk_errors);
        if (errors + chk_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
